// ==== flist.f ====
+incdir+hw
hw/vmode_pkg.sv
hw/cpu_port_decode.sv
hw/quad_fetch.sv
hw/palette_lookup.sv
hw/vmode_chunky.sv
tb/vmode_tb_clock.sv
tb/vram_model.sv
tb/vmode_props.sv
tb/vmode_tb.sv

// ==== hw/cpu_port_decode.sv ====
`include "vmode_config.svh"

module cpu_port_decode import vmode_pkg::*; (
	input bus_req_t i_cpu,
	output bus_rsp_t o_cpu,

	output bus_req_t o_vram_a,
	input bus_rsp_t i_vram_a,

	output palette_wr_t o_palette_wr
);

	cpu_target_e target;
	logic [31:0] palette_offset;
	logic [31:0] palette_word;

	always_comb begin
		if (!i_cpu.request)
			target = TARGET_NONE;
		else if (i_cpu.address < `VMODE_PALETTE_BASE)
			target = TARGET_VRAM;
		else
			target = TARGET_PALETTE;
	end

	// Palette entries sit on 32-bit boundaries
	assign palette_offset = i_cpu.address - `VMODE_PALETTE_BASE;
	assign palette_word = palette_offset >> 2;

	// Port A sees the CPU request unchanged
	always_comb begin
		o_vram_a = i_cpu;
		o_vram_a.request = (target == TARGET_VRAM);
	end

	always_comb begin
		o_palette_wr.strobe = (target == TARGET_PALETTE) && i_cpu.rw;
		o_palette_wr.index = palette_word[7:0];
		o_palette_wr.colour = i_cpu.wdata[23:0]; // Top byte ignored
	end

	always_comb begin
		case (target)
			TARGET_VRAM: begin
				o_cpu.ready = i_vram_a.ready; // VRAM may stall the CPU
				o_cpu.rdata = i_vram_a.rdata;
			end
			TARGET_PALETTE: begin
				// Write only, completes at once
				o_cpu.ready = 1'b1;
				o_cpu.rdata = 32'h0;
			end
			default: begin
				o_cpu.ready = 1'b0;
				o_cpu.rdata = 32'h0;
			end
		endcase
	end

endmodule

// ==== hw/palette_lookup.sv ====
`include "vmode_config.svh"

module palette_lookup import vmode_pkg::*; (
	input logic i_clock,
	input logic i_reset,

	input palette_wr_t i_palette_wr,

	input logic i_video_request,
	input scan_pos_t i_video_pos,
	input logic [31:0] i_quad,
	output rgb_t o_video_rgb
);

	rgb_t palette [`VMODE_PALETTE_SIZE];

	logic [7:0] pixel;
	rgb_t colour;

	// CPU write port
	always_ff @(posedge i_clock) begin
		if (i_palette_wr.strobe)
			palette[i_palette_wr.index] <= i_palette_wr.colour;
	end

	// Byte k is pixel x mod 4 = k
	always_comb begin
		case (i_video_pos.x[1:0])
			2'd0: pixel = i_quad[7:0];
			2'd1: pixel = i_quad[15:8];
			2'd2: pixel = i_quad[23:16];
			default: pixel = i_quad[31:24];
		endcase
	end

	assign colour = palette[pixel];

	// One cycle behind the scan position
	always_ff @(posedge i_clock) begin
		if (i_reset)
			o_video_rgb <= '0;
		else if (i_video_request)
			o_video_rgb <= colour;
		else
			o_video_rgb <= '0; // Blank
	end

endmodule

// ==== hw/quad_fetch.sv ====
`include "vmode_config.svh"

module quad_fetch import vmode_pkg::*; (
	input logic i_clock,
	input logic i_reset,

	input scan_pos_t i_video_pos,

	output bus_req_t o_vram_b,
	input bus_rsp_t i_vram_b,

	output logic [31:0] o_quad
);

	fetch_state_e state;
	logic request;
	logic [31:0] address;
	logic [31:0] next_quad; // Staging, fetched ahead
	logic [31:0] current_quad;

	logic [31:0] ahead_x;
	logic [31:0] line_base;
	logic [31:0] fetch_address;
	logic fetch_start;
	logic quad_start;
	logic quad_arriving;
	logic [31:0] incoming_quad;

	// Two pixels ahead of the scan
	assign ahead_x = {23'd0, i_video_pos.x} + 32'd2;
	assign line_base = {23'd0, i_video_pos.y} * `VMODE_PITCH;
	assign fetch_address = {ahead_x[31:2], 2'b00} + line_base;

	assign fetch_start = (ahead_x[1:0] == 2'd0);
	assign quad_start = (i_video_pos.x[1:0] == 2'd0);

	// Read only port
	always_comb begin
		o_vram_b.request = request;
		o_vram_b.rw = 1'b0;
		o_vram_b.address = address;
		o_vram_b.wdata = 32'h0;
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= FETCH_IDLE;
			request <= 1'b0;
			address <= 32'h0;
			next_quad <= 32'h0;
		end else begin
			case (state)
				FETCH_IDLE: begin
					if (fetch_start) begin
						request <= 1'b1;
						address <= fetch_address; // Held until ready
						state <= FETCH_WAIT;
					end
				end

				FETCH_WAIT: begin
					if (i_vram_b.ready) begin
						request <= 1'b0;
						next_quad <= i_vram_b.rdata;
						state <= FETCH_HOLD;
					end
				end

				FETCH_HOLD: begin
					// Idle again as x reaches 2 mod 4
					if (i_video_pos.x[1:0] == 2'd1)
						state <= FETCH_IDLE;
				end

				default: begin
					request <= 1'b0;
					state <= FETCH_IDLE;
				end
			endcase
		end
	end

	// A quad landing on the boundary cycle goes straight through
	assign quad_arriving = (state == FETCH_WAIT) && i_vram_b.ready;
	assign incoming_quad = quad_arriving ? i_vram_b.rdata : next_quad;

	always_ff @(posedge i_clock) begin
		if (i_reset)
			current_quad <= 32'h0;
		else if (quad_start)
			current_quad <= incoming_quad;
	end

	// New quad is on show from its first pixel
	assign o_quad = quad_start ? incoming_quad : current_quad;

endmodule

// ==== hw/vmode_chunky.sv ====
module vmode_chunky import vmode_pkg::*; (
	input logic i_clock,
	input logic i_reset,

	// CPU
	input bus_req_t i_cpu,
	output bus_rsp_t o_cpu,

	// Video
	input logic i_video_request,
	input scan_pos_t i_video_pos,
	output rgb_t o_video_rgb,

	// VRAM port A, CPU traffic
	output bus_req_t o_vram_a,
	input bus_rsp_t i_vram_a,

	// VRAM port B, pixel fetch
	output bus_req_t o_vram_b,
	input bus_rsp_t i_vram_b
);

	palette_wr_t palette_wr;
	logic [31:0] quad;

	cpu_port_decode cpu_port_decode_inst (
		.i_cpu(i_cpu),
		.o_cpu(o_cpu),
		.o_vram_a(o_vram_a),
		.i_vram_a(i_vram_a),
		.o_palette_wr(palette_wr)
	);

	quad_fetch quad_fetch_inst (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_video_pos(i_video_pos),
		.o_vram_b(o_vram_b),
		.i_vram_b(i_vram_b),
		.o_quad(quad)
	);

	// Quad selected for the current scan position
	palette_lookup palette_lookup_inst (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_palette_wr(palette_wr),
		.i_video_request(i_video_request),
		.i_video_pos(i_video_pos),
		.i_quad(quad),
		.o_video_rgb(o_video_rgb)
	);

endmodule

// ==== hw/vmode_config.svh ====
`ifndef VMODE_CONFIG_SVH
`define VMODE_CONFIG_SVH

// Video memory layout

// Bytes per scan line, one byte per pixel
`define VMODE_PITCH 32'd320

// CPU addresses from here up hit the palette
`define VMODE_PALETTE_BASE 32'h01000000

// Palette entries, one per pixel byte value
`define VMODE_PALETTE_SIZE 256

`endif

// ==== hw/vmode_pkg.sv ====
package vmode_pkg;

	// 0xRRGGBB
	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb_t;

	// Request side of CPU bus and both VRAM ports
	typedef struct packed {
		logic request;
		logic rw; // 1 = write
		logic [31:0] address;
		logic [31:0] wdata;
	} bus_req_t;

	typedef struct packed {
		logic [31:0] rdata;
		logic ready;
	} bus_rsp_t;

	typedef struct packed {
		logic strobe;
		logic [7:0] index;
		rgb_t colour;
	} palette_wr_t;

	typedef struct packed {
		logic [8:0] x;
		logic [8:0] y;
	} scan_pos_t;

	// Where a CPU access goes
	typedef enum logic [1:0] {
		TARGET_NONE,
		TARGET_VRAM,
		TARGET_PALETTE
	} cpu_target_e;

	typedef enum logic [1:0] {
		FETCH_IDLE,
		FETCH_WAIT, // Port B request out
		FETCH_HOLD
	} fetch_state_e;

endpackage

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the vmode_chunky testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "Cannot enter the project directory"
	exit 1
fi

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f flist.f --top-module vmode_tb \
	-Mdir "$BUILD_DIR" -o vmode_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"$BUILD_DIR/vmode_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Errors found" "$LOG"; then
	echo "Simulation reported failures, see $LOG"
	exit 1
fi

if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

echo "Simulation passed"
exit 0

// ==== tb/vmode_props.sv ====
module vmode_props import vmode_pkg::*; (
	input logic i_clock,
	input logic i_reset,
	input bus_req_t i_cpu_req,
	input bus_rsp_t i_cpu_rsp,
	input bus_req_t i_vram_b_req,
	input bus_rsp_t i_vram_b_rsp
);

	// Request and address held until ready
	port_b_held: assert property (@(posedge i_clock) disable iff (i_reset)
		i_vram_b_req.request && !i_vram_b_rsp.ready |=> i_vram_b_req.request
			&& $stable(i_vram_b_req.address))
		else $error("Port B request changed before ready");

	port_b_read_only: assert property (@(posedge i_clock) disable iff (i_reset)
		!i_vram_b_req.rw)
		else $error("Port B write issued");

	port_b_aligned: assert property (@(posedge i_clock) disable iff (i_reset)
		i_vram_b_req.request |-> i_vram_b_req.address[1:0] == 2'b00)
		else $error("Port B address not word aligned");

	cpu_ready_needs_request: assert property (@(posedge i_clock) disable iff (i_reset)
		i_cpu_rsp.ready |-> i_cpu_req.request)
		else $error("CPU ready without a request");

endmodule

// Fetch and CPU ports are both visible at the top level
bind vmode_chunky vmode_props vmode_props_inst (
	.i_clock(i_clock),
	.i_reset(i_reset),
	.i_cpu_req(i_cpu),
	.i_cpu_rsp(o_cpu),
	.i_vram_b_req(o_vram_b),
	.i_vram_b_rsp(i_vram_b)
);

// ==== tb/vmode_tb.sv ====
`include "vmode_config.svh"

module vmode_tb import vmode_pkg::*; ();

	localparam int SCAN_LINES = 3;
	localparam int SCAN_WORDS = SCAN_LINES * `VMODE_PITCH / 4;
	localparam int REWRITES = 16;
	localparam int SCAN_CYCLES = 2 * (SCAN_LINES * `VMODE_PITCH + 2);
	localparam int CPU_CYCLES = 3 * (`VMODE_PALETTE_SIZE + REWRITES)
		+ 6 * (2 * SCAN_WORDS + 2 * REWRITES);
	localparam int TIMEOUT_CYCLES = 2 * (SCAN_CYCLES + CPU_CYCLES) + 1000;

	logic clock;
	logic reset;
	bus_req_t cpu_req;
	bus_rsp_t cpu_rsp;
	logic video_request;
	scan_pos_t video_pos;
	rgb_t video_rgb;
	bus_req_t vram_a_req;
	bus_rsp_t vram_a_rsp;
	bus_req_t vram_b_req;
	bus_rsp_t vram_b_rsp;

	logic [31:0] ref_mem [1024]; // Mirrors CPU writes to VRAM
	rgb_t ref_palette [`VMODE_PALETTE_SIZE];

	integer seed = 32'hb3d4f83d;
	int error_count = 0;
	int cycle_count = 0;
	logic check_enable;
	logic pending_check;
	logic pending_request;
	scan_pos_t pending_pos;
	rgb_t expected_colour;

	vmode_tb_clock vmode_tb_clock_inst (.o_clock(clock));

	vram_model vram_model_inst (
		.i_clock(clock),
		.i_port_a(vram_a_req),
		.o_port_a(vram_a_rsp),
		.i_port_b(vram_b_req),
		.o_port_b(vram_b_rsp)
	);

	vmode_chunky vmode_chunky_inst (
		.i_clock(clock),
		.i_reset(reset),
		.i_cpu(cpu_req),
		.o_cpu(cpu_rsp),
		.i_video_request(video_request),
		.i_video_pos(video_pos),
		.o_video_rgb(video_rgb),
		.o_vram_a(vram_a_req),
		.i_vram_a(vram_a_rsp),
		.o_vram_b(vram_b_req),
		.i_vram_b(vram_b_rsp)
	);

	// Pixel byte (x mod 4) of the aligned word on line y
	function automatic rgb_t expected_rgb(input logic [8:0] x, input logic [8:0] y);
		logic [31:0] byte_address;
		logic [31:0] word;
		logic [1:0] lane;
		byte_address = {23'd0, x[8:2], 2'b00} + {23'd0, y} * `VMODE_PITCH;
		word = ref_mem[byte_address[11:2]];
		lane = x[1:0];
		return ref_palette[word[{lane, 3'b000} +: 8]];
	endfunction

	task automatic report_failure(input string what);
		error_count++;
		$display("%s", what);
		$display("Errors found");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic check_rgb(input string name, input rgb_t got, input rgb_t expected);
		if (got !== expected)
			report_failure($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, expected));
	endtask

	task automatic check_word(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected)
			report_failure($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, expected));
	endtask

	task automatic check_bus(input string name, input bus_req_t got, input bus_req_t expected);
		if (got !== expected)
			report_failure($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, expected));
	endtask

	// Sampled at the rising edge, before the DUT and model update
	task automatic cpu_transfer(input bus_req_t access, output logic [31:0] rdata);
		logic to_palette;
		to_palette = (access.address >= `VMODE_PALETTE_BASE);
		@(negedge clock);
		cpu_req = access;
		@(posedge clock);
		if (to_palette) begin
			if (!cpu_rsp.ready)
				report_failure("Palette access did not complete in its first cycle");
			if (vram_a_req.request)
				report_failure("Port A was requested during a palette access");
		end else begin
			check_bus("o_vram_a", vram_a_req, access);
			while (!cpu_rsp.ready) begin
				@(posedge clock);
				check_bus("o_vram_a", vram_a_req, access);
			end
		end
		rdata = cpu_rsp.rdata;
		@(negedge clock);
		cpu_req = '0;
	endtask

	task automatic write_palette(input logic [7:0] index, input logic [31:0] data);
		bus_req_t access;
		logic [31:0] ignored;
		access.request = 1'b1;
		access.rw = 1'b1;
		access.address = `VMODE_PALETTE_BASE + {22'd0, index, 2'b00};
		access.wdata = data; // Top byte unused by the palette
		cpu_transfer(access, ignored);
		ref_palette[index] = data[23:0];
	endtask

	task automatic write_word(input logic [9:0] index, input logic [31:0] data);
		bus_req_t access;
		logic [31:0] ignored;
		access.request = 1'b1;
		access.rw = 1'b1;
		access.address = {20'd0, index, 2'b00};
		access.wdata = data;
		cpu_transfer(access, ignored);
		ref_mem[index] = data;
	endtask

	task automatic read_word(input logic [9:0] index);
		bus_req_t access;
		logic [31:0] rdata;
		access.request = 1'b1;
		access.rw = 1'b0;
		access.address = {20'd0, index, 2'b00};
		access.wdata = 32'h0;
		cpu_transfer(access, rdata);
		check_word($sformatf("o_cpu.rdata at 0x%h", access.address), rdata, ref_mem[index]);
	endtask

	// Blank window on one line, blank_line of -1 for none
	task automatic run_scan(input int blank_line, input int blank_first, input int blank_last);
		for (int y = 0; y < SCAN_LINES; y++) begin
			for (int x = 0; x < `VMODE_PITCH; x++) begin
				@(negedge clock);
				video_pos.x = 9'(x);
				video_pos.y = 9'(y);
				video_request = !(y == blank_line && x >= blank_first && x <= blank_last);
				check_enable = !(y == 0 && x < 4); // Nothing prefetched yet
			end
		end
		@(negedge clock);
		video_request = 1'b0;
		video_pos = '0;
		check_enable = 1'b0;
	endtask

	always @(posedge clock) begin
		pending_check <= check_enable;
		pending_request <= video_request;
		pending_pos <= video_pos;
		cycle_count <= cycle_count + 1;
	end

	// Colour for the position of the previous cycle
	always @(negedge clock) begin
		if (pending_check) begin
			if (pending_request)
				expected_colour = expected_rgb(pending_pos.x, pending_pos.y);
			else
				expected_colour = '0;
			check_rgb($sformatf("o_video_rgb at x=%0d y=%0d", pending_pos.x, pending_pos.y),
				video_rgb, expected_colour);
		end
	end

	always @(posedge clock) begin
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Errors found");
			$fatal(1, "Timeout");
		end
	end

	initial begin
		logic [9:0] index;
		cpu_req = '0;
		video_request = 1'b0;
		video_pos = '0;
		check_enable = 1'b0;
		reset = 1'b1;
		repeat (10) @(negedge clock);
		reset = 1'b0;

		repeat (4) @(negedge clock);
		if (vram_b_req.request)
			report_failure("Port B requested while idle after reset");
		check_rgb("o_video_rgb", video_rgb, '0);

		for (int i = 0; i < `VMODE_PALETTE_SIZE; i++)
			write_palette(8'(i), $random(seed));
		for (int i = 0; i < SCAN_WORDS; i++)
			write_word(10'(i), $random(seed));
		for (int i = 0; i < SCAN_WORDS; i++)
			read_word(10'(i));

		run_scan(-1, 0, 0);

		// New colours and pixels for the second scan
		for (int i = 0; i < REWRITES; i++) begin
			write_palette(8'($random(seed)), $random(seed));
			index = 10'($unsigned($random(seed)) % SCAN_WORDS);
			write_word(index, $random(seed));
			read_word(index);
		end

		run_scan(1, 100, 139);
		repeat (2) @(negedge clock);

		if (error_count == 0) begin
			$display("No errors");
			$finish;
		end else begin
			$display("Errors found");
			$fatal(1, "Checks failed");
		end
	end

endmodule

// ==== tb/vmode_tb_clock.sv ====
module vmode_tb_clock (
	output logic o_clock
);

	initial o_clock = 1'b0;

	always #5 o_clock = ~o_clock; // Period of 10

endmodule

// ==== tb/vram_model.sv ====
module vram_model import vmode_pkg::*; (
	input logic i_clock,

	input bus_req_t i_port_a,
	output bus_rsp_t o_port_a,

	input bus_req_t i_port_b,
	output bus_rsp_t o_port_b
);

	logic [31:0] words [1024];
	integer seed;
	logic [1:0] a_wait; // Wait cycles for the current port A transfer
	logic [1:0] a_count;
	logic a_ready;
	logic b_ready;
	logic [31:0] b_rdata;

	initial begin
		seed = 32'hb3d4f83d;
		a_wait = 2'($random(seed));
		a_count = 2'd0;
		b_ready = 1'b0;
		b_rdata = 32'h0;
		for (int i = 0; i < 1024; i++)
			words[i] = (32'(i) * 32'h9e3779b1) ^ 32'h5a5a0000;
	end

	// Port A, 0 to 3 random wait cycles
	assign a_ready = i_port_a.request && (a_count == a_wait);
	assign o_port_a.ready = a_ready;
	assign o_port_a.rdata = words[i_port_a.address[11:2]];

	always @(posedge i_clock) begin
		if (i_port_a.request) begin
			if (a_ready) begin
				if (i_port_a.rw)
					words[i_port_a.address[11:2]] <= i_port_a.wdata;
				a_count <= 2'd0;
				a_wait <= 2'($random(seed));
			end else
				a_count <= a_count + 2'd1;
		end
	end

	// Port B answers one cycle after the request
	always @(posedge i_clock) begin
		if (b_ready)
			b_ready <= 1'b0;
		else if (i_port_b.request) begin
			b_ready <= 1'b1;
			b_rdata <= words[i_port_b.address[11:2]];
		end
	end

	assign o_port_b.ready = b_ready;
	assign o_port_b.rdata = b_rdata;

endmodule
